// ==== src/adpcma_pkg.sv ====
`default_nettype none

package adpcma_pkg;

    // ==================================================
    // register map
    // ==================================================

    localparam int reg_addr_w = 3;

    localparam logic [reg_addr_w-1:0] reg_start_lo = 3'd0;
    localparam logic [reg_addr_w-1:0] reg_start_hi = 3'd1;
    localparam logic [reg_addr_w-1:0] reg_end_lo   = 3'd2;
    localparam logic [reg_addr_w-1:0] reg_end_hi   = 3'd3;
    localparam logic [reg_addr_w-1:0] reg_level    = 3'd4;
    // bit 0 is key-on and bit 1 is key-off, neither is stored
    localparam logic [reg_addr_w-1:0] reg_ctrl     = 3'd5;
    // bit 0 is busy and bit 1 is the sticky end flag
    localparam logic [reg_addr_w-1:0] reg_status   = 3'd6;

    localparam int rom_addr_w = 16;
    localparam int level_w    = 6;

    // ==================================================
    // ADPCM-A step adaptation
    // ==================================================

    localparam int step_max = 48;

    // step sizes grow by roughly 10 percent per index
    localparam logic [11:0] step_size_table [0:48] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,
        12'd25,   12'd28,   12'd31,   12'd34,   12'd37,
        12'd41,   12'd45,   12'd50,   12'd55,   12'd60,
        12'd66,   12'd73,   12'd80,   12'd88,   12'd97,
        12'd107,  12'd118,  12'd130,  12'd143,  12'd157,
        12'd173,  12'd190,  12'd209,  12'd230,  12'd253,
        12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,
        12'd724,  12'd796,  12'd876,  12'd963,  12'd1060,
        12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // index increase for magnitudes 4 to 7, smaller magnitudes step down by one
    localparam logic [3:0] step_delta_table [0:3] = '{
        4'd2, 4'd5, 4'd7, 4'd9
    };

    // ==================================================
    // fetch FSM
    // ==================================================

    typedef enum logic [1:0] {
        idle = 2'd0,
        load = 2'd1,
        play = 2'd2
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== src/adpcma_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module adpcma_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [adpcma_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [7:0]                        reg_wdata,
    input  logic                              reg_wr,
    input  logic                              busy,
    input  logic                              end_pulse,
    output logic [7:0]                        reg_rdata,
    output logic [adpcma_pkg::rom_addr_w-1:0] start_addr,
    output logic [adpcma_pkg::rom_addr_w-1:0] end_addr,
    output logic [adpcma_pkg::level_w-1:0]    level,
    output logic                              key_on,
    output logic                              key_off
);

    import adpcma_pkg::*;

    logic [7:0]         start_lo;
    logic [7:0]         start_hi;
    logic [7:0]         end_lo;
    logic [7:0]         end_hi;
    logic [level_w-1:0] level_q;
    logic               end_flag;
    logic               wr_ctrl;

    // control writes become pulses in the same cycle as the write
    assign wr_ctrl = reg_wr && (reg_addr == reg_ctrl);
    assign key_on  = wr_ctrl && reg_wdata[0];
    assign key_off = wr_ctrl && reg_wdata[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_lo <= 8'h00;
            start_hi <= 8'h00;
            end_lo   <= 8'h00;
            end_hi   <= 8'h00;
            level_q  <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                reg_start_lo: start_lo <= reg_wdata;
                reg_start_hi: start_hi <= reg_wdata;
                reg_end_lo:   end_lo   <= reg_wdata;
                reg_end_hi:   end_hi   <= reg_wdata;
                reg_level:    level_q  <= reg_wdata[level_w-1:0];
                default: ;
            endcase
        end
    end

    // a new key-on clears the flag even if the old stream ends in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_flag <= 1'b0;
        end else if (key_on) begin
            end_flag <= 1'b0;
        end else if (end_pulse) begin
            end_flag <= 1'b1;
        end
    end

    assign start_addr = {start_hi, start_lo};
    assign end_addr   = {end_hi, end_lo};
    assign level      = level_q;

    always_comb begin
        case (reg_addr)
            reg_start_lo: reg_rdata = start_lo;
            reg_start_hi: reg_rdata = start_hi;
            reg_end_lo:   reg_rdata = end_lo;
            reg_end_hi:   reg_rdata = end_hi;
            reg_level:    reg_rdata = {{(8 - level_w){1'b0}}, level_q};
            reg_status:   reg_rdata = {6'b000000, end_flag, busy};
            default:      reg_rdata = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/adpcma_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module adpcma_fetch (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              key_on,
    input  logic                              key_off,
    input  logic [adpcma_pkg::rom_addr_w-1:0] start_addr,
    input  logic [adpcma_pkg::rom_addr_w-1:0] end_addr,
    input  logic                              sample_en,
    input  logic [7:0]                        rom_data,
    output logic                              rom_rd,
    output logic [adpcma_pkg::rom_addr_w-1:0] rom_addr,
    output logic [3:0]                        code,
    output logic                              code_valid,
    output logic                              restart,
    output logic                              busy,
    output logic                              end_pulse
);

    import adpcma_pkg::*;

    fetch_state_t state;
    logic [7:0]   byte_q;
    logic         nib_lo;
    logic         rd_dly;

    assign busy = (state != idle);

    // ROM data arrives one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (rd_dly) begin
            byte_q <= rom_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            nib_lo     <= 1'b0;
            rd_dly     <= 1'b0;
            rom_rd     <= 1'b0;
            rom_addr   <= '0;
            code       <= 4'h0;
            code_valid <= 1'b0;
            restart    <= 1'b0;
            end_pulse  <= 1'b0;
        end else begin
            rom_rd     <= 1'b0;
            code_valid <= 1'b0;
            restart    <= 1'b0;
            end_pulse  <= 1'b0;
            rd_dly     <= rom_rd;

            if (key_on) begin
                state    <= load;
                rom_addr <= start_addr;
                rom_rd   <= 1'b1;
                restart  <= 1'b1;
                nib_lo   <= 1'b0;
            end else if (key_off) begin
                state <= idle;
            end else begin
                case (state)
                    // wait for the first byte, a stale read from before a retrigger must not count
                    load: begin
                        if (rd_dly && !rom_rd) begin
                            state <= play;
                        end
                    end
                    play: begin
                        if (sample_en) begin
                            code_valid <= 1'b1;
                            if (!nib_lo) begin
                                code   <= byte_q[7:4];
                                nib_lo <= 1'b1;
                            end else begin
                                code   <= byte_q[3:0];
                                nib_lo <= 1'b0;
                                if (rom_addr == end_addr) begin
                                    end_pulse <= 1'b1;
                                    state     <= idle;
                                end else begin
                                    rom_rd   <= 1'b1;
                                    rom_addr <= rom_addr + 1'b1;
                                end
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/adpcma_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module adpcma_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [3:0]                     code,
    input  logic                           code_valid,
    input  logic                           restart,
    input  logic [adpcma_pkg::level_w-1:0] level,
    output logic signed [15:0]             pcm,
    output logic                           pcm_valid
);

    import adpcma_pkg::*;

    logic [5:0]          step_q;
    logic [5:0]          step_next;
    logic [6:0]          step_up;
    logic [2:0]          mag;
    logic [15:0]         inc_prod;
    logic signed [17:0]  acc_ext;
    logic signed [17:0]  inc_ext;
    logic signed [17:0]  acc_sum;
    logic signed [15:0]  acc_q;
    logic signed [15:0]  acc_next;
    logic signed [6:0]   level_s;
    logic signed [22:0]  scaled;
    logic                s1_valid;

    assign mag = code[2:0];

    // ==================================================
    // stage 1: step adaptation and accumulation
    // ==================================================

    always_comb begin
        step_up = {1'b0, step_q} + {3'b000, step_delta_table[mag[1:0]]};
        if (!mag[2]) begin
            step_next = (step_q == 6'd0) ? 6'd0 : step_q - 6'd1;
        end else if (step_up > 7'(step_max)) begin
            step_next = 6'(step_max);
        end else begin
            step_next = step_up[5:0];
        end
    end

    // the increment is taken from the step index before it adapts
    always_comb begin
        inc_prod = {12'd0, mag, 1'b1} * {4'd0, step_size_table[step_q]};
        inc_ext  = $signed({5'd0, inc_prod[15:3]});
        acc_ext  = {{2{acc_q[15]}}, acc_q};
        acc_sum  = code[3] ? (acc_ext + inc_ext) : (acc_ext - inc_ext);
        if (acc_sum > 18'sd32767) begin
            acc_next = 16'sh7fff;
        end else if (acc_sum < -18'sd32768) begin
            acc_next = 16'sh8000;
        end else begin
            acc_next = acc_sum[15:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q   <= 6'd0;
            acc_q    <= 16'sd0;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= code_valid && !restart;
            if (restart) begin
                step_q <= 6'd0;
                acc_q  <= 16'sd0;
            end else if (code_valid) begin
                step_q <= step_next;
                acc_q  <= acc_next;
            end
        end
    end

    // ==================================================
    // stage 2: output level
    // ==================================================

    // an arithmetic product keeps the divide by 64 a floor for negative values
    assign level_s = $signed({1'b0, level});
    assign scaled  = acc_q * level_s;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm       <= 16'sd0;
            pcm_valid <= 1'b0;
        end else begin
            pcm_valid <= s1_valid;
            if (s1_valid) begin
                pcm <= scaled[21:6];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/adpcma_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module adpcma_channel (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [adpcma_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [7:0]                        reg_wdata,
    input  logic                              reg_wr,
    output logic [7:0]                        reg_rdata,
    input  logic                              sample_en,
    output logic                              rom_rd,
    output logic [adpcma_pkg::rom_addr_w-1:0] rom_addr,
    input  logic [7:0]                        rom_data,
    output logic signed [15:0]                pcm,
    output logic                              pcm_valid,
    output logic                              busy
);

    import adpcma_pkg::*;

    logic [rom_addr_w-1:0] start_addr;
    logic [rom_addr_w-1:0] end_addr;
    logic [level_w-1:0]    level;
    logic                  key_on;
    logic                  key_off;
    logic                  end_pulse;
    logic [3:0]            code;
    logic                  code_valid;
    logic                  restart;

    adpcma_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_wr     (reg_wr),
        .busy       (busy),
        .end_pulse  (end_pulse),
        .reg_rdata  (reg_rdata),
        .start_addr (start_addr),
        .end_addr   (end_addr),
        .level      (level),
        .key_on     (key_on),
        .key_off    (key_off)
    );

    adpcma_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_on     (key_on),
        .key_off    (key_off),
        .start_addr (start_addr),
        .end_addr   (end_addr),
        .sample_en  (sample_en),
        .rom_data   (rom_data),
        .rom_rd     (rom_rd),
        .rom_addr   (rom_addr),
        .code       (code),
        .code_valid (code_valid),
        .restart    (restart),
        .busy       (busy),
        .end_pulse  (end_pulse)
    );

    adpcma_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .code       (code),
        .code_valid (code_valid),
        .restart    (restart),
        .level      (level),
        .pcm        (pcm),
        .pcm_valid  (pcm_valid)
    );

endmodule

`default_nettype wire

// ==== testbench/adpcma_channel_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module adpcma_channel_assert (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         sample_en,
    input wire                         pcm_valid,
    input wire                         rom_rd,
    input wire                         busy,
    input wire                         key_on,
    input wire                         key_off,
    input adpcma_pkg::fetch_state_t    state
);

    import adpcma_pkg::*;

    // a key write in the same cycle takes priority over the sample strobe
    property p_pcm_latency;
        @(posedge clk) disable iff (!rst_n)
            (sample_en && state == play && !key_on && !key_off) |-> ##3 pcm_valid;
    endproperty
    a_pcm_latency: assert property (p_pcm_latency) else $error("pcm_valid latency wrong");

    a_no_read_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(rom_rd && state == idle)) else $error("rom_rd high in idle");

    a_busy_needs_key: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && !key_on) |=> !busy) else $error("busy rose without a key-on");

endmodule

bind adpcma_channel adpcma_channel_assert u_assert (
    .clk (clk), .rst_n (rst_n), .sample_en (sample_en), .pcm_valid (pcm_valid),
    .rom_rd (rom_rd), .busy (busy), .key_on (key_on), .key_off (key_off),
    .state (u_fetch.state)
);

`default_nettype wire

// ==== testbench/adpcma_channel_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module adpcma_channel_tb;

    import adpcma_pkg::*;

    localparam int sample_gap    = 5;
    localparam int total_samples = 32 + 64 + 144 + 45;
    localparam int timeout_ns    = total_samples * sample_gap * 20 * 2 + 50000;

    logic                  clk;
    logic                  rst_n;
    logic [reg_addr_w-1:0] reg_addr;
    logic [7:0]            reg_wdata;
    logic                  reg_wr;
    logic [7:0]            reg_rdata;
    logic                  sample_en;
    logic                  rom_rd;
    logic [rom_addr_w-1:0] rom_addr;
    logic [7:0]            rom_data;
    logic signed [15:0]    pcm;
    logic                  pcm_valid;
    logic                  busy;

    logic [7:0] rom_mem [0:65535];
    int         pcm_q [$];
    int         exp_q [$];
    int         model_acc;
    int         model_step;
    int         errors;
    int         checks;
    int         tests_run;

    adpcma_channel u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_wr    (reg_wr),
        .reg_rdata (reg_rdata),
        .sample_en (sample_en),
        .rom_rd    (rom_rd),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pcm       (pcm),
        .pcm_valid (pcm_valid),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // the sample ROM answers one cycle after the read strobe
    always @(posedge clk) begin
        if (rom_rd) begin
            rom_data <= rom_mem[rom_addr];
        end
    end

    always @(negedge clk) begin
        if (pcm_valid) begin
            pcm_q.push_back(int'(pcm));
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the tests did not finish in %0d ns", timeout_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ==================================================
    // reference decoder
    // ==================================================

    function automatic int model_decode(input logic [3:0] code, input int lvl);
        int mag;
        int inc;
        mag = int'(code[2:0]);
        inc = ((2 * mag + 1) * int'(step_size_table[model_step])) / 8;
        model_acc = code[3] ? model_acc + inc : model_acc - inc;
        if (model_acc > 32767) model_acc = 32767;
        if (model_acc < -32768) model_acc = -32768;
        if (mag < 4) begin
            model_step = (model_step > 0) ? model_step - 1 : 0;
        end else begin
            model_step = model_step + int'(step_delta_table[mag - 4]);
            if (model_step > step_max) model_step = step_max;
        end
        return (model_acc * lvl) >>> 6;
    endfunction

    task automatic write_reg(input logic [reg_addr_w-1:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(posedge clk);
        #2;
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [reg_addr_w-1:0] addr, output logic [7:0] data);
        @(posedge clk);
        #2;
        reg_addr = addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s read %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic pulse_sample();
        @(posedge clk);
        #2;
        sample_en = 1'b1;
        @(posedge clk);
        #2;
        sample_en = 1'b0;
        repeat (sample_gap - 2) @(posedge clk);
    endtask

    task automatic key_on_and_wait();
        int n;
        write_reg(reg_ctrl, 8'h01);
        n = 0;
        while (!busy && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!busy) begin
            errors++;
            $display("busy did not rise after a key-on at %0t", $time);
        end
        repeat (3) @(posedge clk);
    endtask

    // sets up a region, predicts its first nsamples outputs and plays them
    task automatic play_region(input int start, input int nbytes, input int lvl, input int nsamples);
        logic [7:0] b;
        write_reg(reg_start_lo, start[7:0]);
        write_reg(reg_start_hi, start[15:8]);
        write_reg(reg_end_lo, 8'((start + nbytes - 1) & 255));
        write_reg(reg_end_hi, 8'((start + nbytes - 1) >> 8));
        write_reg(reg_level, 8'(lvl));
        pcm_q.delete();
        exp_q.delete();
        model_acc  = 0;
        model_step = 0;
        for (int i = 0; i < nsamples; i++) begin
            b = rom_mem[start + i / 2];
            exp_q.push_back(model_decode((i % 2 == 0) ? b[7:4] : b[3:0], lvl));
        end
        key_on_and_wait();
        for (int i = 0; i < nsamples; i++) begin
            pulse_sample();
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic compare_stream(input string what);
        checks++;
        if (pcm_q.size() != exp_q.size()) begin
            errors++;
            $display("CHECK FAILED at %0t: %s gave %0d pcm values, expected %0d",
                     $time, what, pcm_q.size(), exp_q.size());
        end else begin
            for (int i = 0; i < exp_q.size(); i++) begin
                if (pcm_q[i] != exp_q[i]) begin
                    errors++;
                    $display("CHECK FAILED at %0t: %s sample %0d is %0d, expected %0d",
                             $time, what, i, pcm_q[i], exp_q[i]);
                end
            end
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================

    task automatic register_access();
        logic [7:0] d;
        read_reg(reg_status, d);
        check_byte(d, 8'h00, "status after reset");
        write_reg(reg_start_lo, 8'h5a);
        write_reg(reg_start_hi, 8'ha5);
        write_reg(reg_end_lo, 8'h3c);
        write_reg(reg_end_hi, 8'hc3);
        write_reg(reg_level, 8'h2b);
        read_reg(reg_start_lo, d);
        check_byte(d, 8'h5a, "start low");
        read_reg(reg_start_hi, d);
        check_byte(d, 8'ha5, "start high");
        read_reg(reg_end_lo, d);
        check_byte(d, 8'h3c, "end low");
        read_reg(reg_end_hi, d);
        check_byte(d, 8'hc3, "end high");
        read_reg(reg_level, d);
        check_byte(d, 8'h2b, "level");
        tests_run++;
        $display("test register access finished, errors so far %0d", errors);
    endtask

    task automatic full_scale_playback();
        logic [7:0] d;
        play_region(16'h0120, 16, 63, 32);
        compare_stream("full scale");
        read_reg(reg_status, d);
        check_byte(d, 8'h02, "status after playback");
        tests_run++;
        $display("test full-scale playback finished, errors so far %0d", errors);
    endtask

    task automatic level_scaling();
        play_region(16'h0120, 16, 0, 32);
        compare_stream("level 0");
        play_region(16'h0120, 16, 32, 32);
        compare_stream("level 32");
        tests_run++;
        $display("test level scaling finished, errors so far %0d", errors);
    endtask

    task automatic saturation_and_clamp();
        bit hit_max;
        bit hit_min;
        for (int i = 0; i < 72; i++) begin
            rom_mem[16'h4000 + i] = (i < 16) ? 8'h77 : (i < 40) ? 8'hff : 8'h00;
        end
        play_region(16'h4000, 72, 63, 144);
        compare_stream("saturation");
        hit_max = 1'b0;
        hit_min = 1'b0;
        foreach (pcm_q[i]) begin
            if (pcm_q[i] == 32255) hit_max = 1'b1;
            if (pcm_q[i] == -32256) hit_min = 1'b1;
        end
        checks++;
        if (!hit_max || !hit_min || u_dut.u_decode.step_q != 6'd0) begin
            errors++;
            $display("CHECK FAILED at %0t: saturation max %0b min %0b final step %0d",
                     $time, hit_max, hit_min, u_dut.u_decode.step_q);
        end
        tests_run++;
        $display("test saturation and step clamp finished, errors so far %0d", errors);
    endtask

    task automatic key_off_retrigger();
        logic [7:0] d;
        play_region(16'h0120, 16, 63, 10);
        write_reg(reg_ctrl, 8'h02);
        repeat (3) pulse_sample();
        compare_stream("before key-off");
        read_reg(reg_status, d);
        check_byte(d, 8'h00, "status after key-off");
        play_region(16'h0120, 16, 63, 32);
        compare_stream("retrigger");
        tests_run++;
        $display("test key-off and retrigger finished, errors so far %0d", errors);
    endtask

    initial begin
        rst_n     = 1'b0;
        reg_addr  = '0;
        reg_wdata = 8'h00;
        reg_wr    = 1'b0;
        sample_en = 1'b0;
        rom_data  = 8'h00;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        void'($urandom(32'hd80b896e));
        for (int i = 0; i < 65536; i++) begin
            rom_mem[i] = 8'($urandom);
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        register_access();
        full_scale_playback();
        level_scaling();
        saturation_and_clamp();
        key_off_retrigger();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== adpcma_channel.f ====
src/adpcma_pkg.sv
src/adpcma_regs.sv
src/adpcma_fetch.sv
src/adpcma_decode.sv
src/adpcma_channel.sv
testbench/adpcma_channel_assert.sv
testbench/adpcma_channel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the ADPCM-A channel testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module adpcma_channel_tb \
    -f adpcma_channel.f \
    -o Vadpcma_channel_tb
status=$?
if [ $status -ne 0 ]; then
    echo "compile step failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vadpcma_channel_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
